//--- source/dcache_pkg.sv
// geometry is fixed here: two ways, 16 sets, 4-word lines, 32-bit byte addresses
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int WAYS       = 2;
    localparam int SETS       = 16;
    localparam int LINE_WORDS = 4;
    localparam int INDEX_W    = 4;
    localparam int WORD_W     = 2;
    // what is left above word, index and byte fields
    localparam int TAG_W      = 32 - INDEX_W - WORD_W - 2;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [WORD_W-1:0]  word;
        logic [1:0]         byte_off;
    } addr_fields_t;

    // bus address and cache view of the same word
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } addr_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    // addr is always line aligned
    typedef struct packed {
        logic  rd_req;
        logic  wr_req;
        addr_t addr;
    } mem_cmd_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_wbeat_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_SEND,
        RF_REQ,
        RF_WAIT,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/dcache_tag_store.sv
// one index for read and write; replacement bit logic assumes exactly two ways
`default_nettype none

module dcache_tag_store (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [dcache_pkg::INDEX_W-1:0]              rd_index,
    output logic [dcache_pkg::WAYS-1:0][dcache_pkg::TAG_W-1:0] tags,
    output logic [dcache_pkg::WAYS-1:0]                 valid,
    output logic [dcache_pkg::WAYS-1:0]                 dirty,
    output logic                                        lru_way,
    input  logic                                        wr_way,
    input  logic                                        tag_we,
    input  logic [dcache_pkg::TAG_W-1:0]                wr_tag,
    input  logic                                        dirty_set,
    input  logic                                        dirty_clear,
    input  logic                                        touch,
    input  logic                                        touch_way
);
    import dcache_pkg::*;

    logic [WAYS-1:0][TAG_W-1:0] tag_mem [SETS];
    logic [SETS-1:0][WAYS-1:0]  valid_q;
    logic [SETS-1:0][WAYS-1:0]  dirty_q;
    logic [SETS-1:0]            lru_q;

    logic [WAYS-1:0] valid_nxt;
    logic [WAYS-1:0] dirty_nxt;
    logic            lru_nxt;

    // state of the addressed set after this cycle's updates
    always_comb begin
        valid_nxt = valid_q[rd_index];
        dirty_nxt = dirty_q[rd_index];
        lru_nxt   = lru_q[rd_index];
        if (tag_we) begin
            valid_nxt[wr_way] = 1'b1;
        end
        if (dirty_clear) begin
            dirty_nxt[wr_way] = 1'b0;
        end
        if (dirty_set) begin
            dirty_nxt[wr_way] = 1'b1;
        end
        // point at the other way
        if (touch) begin
            lru_nxt = ~touch_way;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            valid   <= '0;
            dirty   <= '0;
            lru_way <= 1'b0;
        end else begin
            valid_q[rd_index] <= valid_nxt;
            dirty_q[rd_index] <= dirty_nxt;
            lru_q[rd_index]   <= lru_nxt;
            // read returns the updated bits
            valid   <= valid_nxt;
            dirty   <= dirty_nxt;
            lru_way <= lru_nxt;
        end
    end

    // tag array, new tag forwarded to the read port
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[rd_index][wr_way] <= wr_tag;
        end
        for (int w = 0; w < WAYS; w++) begin
            if (tag_we && wr_way == 1'(w)) begin
                tags[w] <= wr_tag;
            end else begin
                tags[w] <= tag_mem[rd_index][w];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_data_store.sv
// no reset on the array; a read in the same cycle as a write to that word sees the new bytes
`default_nettype none

module dcache_data_store (
    input  logic                                 clk,
    input  logic [dcache_pkg::INDEX_W-1:0]       rd_index,
    output dcache_pkg::word_t [dcache_pkg::WAYS-1:0][dcache_pkg::LINE_WORDS-1:0] rd_line,
    input  logic                                 wr_way,
    input  logic [dcache_pkg::INDEX_W-1:0]       wr_index,
    input  logic [dcache_pkg::WORD_W-1:0]        wr_word,
    input  dcache_pkg::strb_t                    wr_strb,
    input  dcache_pkg::word_t                    wr_data,
    input  logic                                 we
);
    import dcache_pkg::*;

    localparam int BYTES = $bits(strb_t);

    word_t [WAYS-1:0][LINE_WORDS-1:0] mem [SETS];
    logic same_set;

    assign same_set = we && (wr_index == rd_index);

    // byte lanes written in place
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_index][wr_way][wr_word][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // whole set per read, for hit select and write-back
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (same_set && wr_way == 1'(w) && wr_word == WORD_W'(k)
                            && wr_strb[b]) begin
                        rd_line[w][k][8*b +: 8] <= wr_data[8*b +: 8];
                    end else begin
                        rd_line[w][k][8*b +: 8] <= mem[rd_index][w][k][8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_beat_counter.sv
// wraps after LINE_WORDS beats, so LINE_WORDS must be a power of two
`default_nettype none

module dcache_beat_counter (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            en,
    input  logic                            clear,
    output logic [dcache_pkg::WORD_W-1:0]   count,
    output logic                            last
);
    import dcache_pkg::*;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (en) begin
            count <= count + 1'b1;
        end
    end

    assign last = (count == WORD_W'(LINE_WORDS - 1));

    // a burst never runs straight on into the next one
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        (en && last) |=> (!en || clear))
        else $error("beat counter ran past the last word");

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
// one request at a time; a refilled line is always looked up again before the response
`default_nettype none

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cpu_valid,
    output logic                    cpu_done,
    input  logic                    hit,
    input  logic                    hit_way,
    input  logic                    victim_dirty,
    input  logic                    req_write,
    input  logic                    mem_rd_rdy,
    input  logic                    mem_wr_rdy,
    input  logic                    mem_ret_valid,
    input  logic                    beat_last,
    output dcache_pkg::ctrl_state_t state,
    output logic                    beat_en,
    output logic                    tag_we,
    output logic                    data_we_word,
    output logic                    rd_req,
    output logic                    wr_req
);
    import dcache_pkg::*;

    ctrl_state_t state_next;
    logic        ret_beat;
    logic        store_hit;

    assign ret_beat  = (state == RF_WAIT) && mem_ret_valid;
    assign store_hit = (state == LOOKUP) && hit && req_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cpu_valid) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_next = DONE;
                end else if (victim_dirty) begin
                    state_next = WB_REQ;
                end else begin
                    state_next = RF_REQ;
                end
            end
            WB_REQ: begin
                if (mem_wr_rdy) begin
                    state_next = WB_SEND;
                end
            end
            // one word per cycle, memory cannot stall
            WB_SEND: begin
                if (beat_last) begin
                    state_next = RF_REQ;
                end
            end
            RF_REQ: begin
                if (mem_rd_rdy) begin
                    state_next = RF_WAIT;
                end
            end
            RF_WAIT: begin
                if (ret_beat && beat_last) begin
                    state_next = LOOKUP;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign cpu_done     = (state == DONE);
    assign wr_req       = (state == WB_REQ);
    assign rd_req       = (state == RF_REQ);
    assign beat_en      = (state == WB_SEND) || ret_beat;
    // tag goes in with the last refill word
    assign tag_we       = ret_beat && beat_last;
    assign data_we_word = store_hit || ret_beat;

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        cpu_done |=> !cpu_done)
        else $error("cpu_done longer than one cycle");

    a_valid_held: assert property (@(posedge clk) disable iff (reset)
        (state != IDLE) |-> cpu_valid)
        else $error("cpu_valid dropped before cpu_done");

    // tag store must show the new line on the very next lookup
    a_refill_hits: assert property (@(posedge clk) disable iff (reset)
        (ret_beat && beat_last) |=> hit)
        else $error("lookup after refill missed");

    // lru and dirty updates leave the hit way alone
    a_hit_way_stable: assert property (@(posedge clk) disable iff (reset)
        (state == LOOKUP && hit) |=> (hit && $stable(hit_way)))
        else $error("hit way changed between lookup and response");

endmodule

`default_nettype wire

//--- source/dcache_top.sv
// processor must hold cpu_valid and cpu_req until cpu_done; memory takes write bursts unstalled
`default_nettype none

module dcache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cpu_valid,
    input  dcache_pkg::cpu_req_t    cpu_req,
    output logic                    cpu_done,
    output dcache_pkg::word_t       cpu_rdata,
    output dcache_pkg::mem_cmd_t    mem_cmd,
    output dcache_pkg::mem_wbeat_t  mem_wbeat,
    input  logic                    mem_rd_rdy,
    input  logic                    mem_wr_rdy,
    input  logic                    mem_ret_valid,
    input  dcache_pkg::word_t       mem_ret_data
);
    import dcache_pkg::*;

    ctrl_state_t                      state;
    cpu_req_t                         req_q;
    word_t                            rdata_q;
    logic [INDEX_W-1:0]               rd_index;
    logic [WAYS-1:0][TAG_W-1:0]       tags;
    logic [WAYS-1:0]                  valid;
    logic [WAYS-1:0]                  dirty;
    logic [WAYS-1:0]                  hit_vec;
    logic                             lru_way;
    logic                             hit;
    logic                             hit_way;
    logic                             victim_dirty;
    word_t [WAYS-1:0][LINE_WORDS-1:0] rd_line;
    word_t                            hit_word;
    word_t                            merged_word;
    logic [WORD_W-1:0]                beat_count;
    logic                             beat_last;
    logic                             beat_en;
    logic                             tag_we;
    logic                             data_we_word;
    logic                             rd_req;
    logic                             wr_req;
    logic                             in_lookup;
    logic                             refill;
    addr_t                            victim_addr;
    addr_t                            refill_addr;

    assign in_lookup = (state == LOOKUP);
    assign refill    = (state == RF_WAIT);

    // request held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_valid) begin
            req_q <= cpu_req;
        end
    end

    // set is read straight from the bus while idle
    assign rd_index = (state == IDLE) ? cpu_req.addr.fields.index : req_q.addr.fields.index;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid[w] && (tags[w] == req_q.addr.fields.tag);
        end
    end

    assign hit          = |hit_vec;
    assign hit_way      = hit_vec[1];
    assign victim_dirty = valid[lru_way] && dirty[lru_way];
    assign hit_word     = rd_line[hit_way][req_q.addr.fields.word];

    always_comb begin
        for (int b = 0; b < $bits(strb_t); b++) begin
            merged_word[8*b +: 8] = req_q.strb[b] ? req_q.wdata[8*b +: 8] : hit_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (in_lookup && hit) begin
            rdata_q <= req_q.write ? merged_word : hit_word;
        end
    end

    assign cpu_rdata = rdata_q;

    // line addresses, word and byte fields cleared
    always_comb begin
        victim_addr                 = req_q.addr;
        victim_addr.fields.tag      = tags[lru_way];
        victim_addr.fields.word     = '0;
        victim_addr.fields.byte_off = '0;
        refill_addr                 = req_q.addr;
        refill_addr.fields.word     = '0;
        refill_addr.fields.byte_off = '0;
    end

    assign mem_cmd.rd_req  = rd_req;
    assign mem_cmd.wr_req  = wr_req;
    assign mem_cmd.addr    = wr_req ? victim_addr : refill_addr;
    assign mem_wbeat.valid = (state == WB_SEND);
    assign mem_wbeat.data  = rd_line[lru_way][beat_count];

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .cpu_valid     (cpu_valid),
        .cpu_done      (cpu_done),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_dirty  (victim_dirty),
        .req_write     (req_q.write),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_ret_valid (mem_ret_valid),
        .beat_last     (beat_last),
        .state         (state),
        .beat_en       (beat_en),
        .tag_we        (tag_we),
        .data_we_word  (data_we_word),
        .rd_req        (rd_req),
        .wr_req        (wr_req)
    );

    dcache_beat_counter u_beat (
        .clk   (clk),
        .reset (reset),
        .en    (beat_en),
        .clear (in_lookup),
        .count (beat_count),
        .last  (beat_last)
    );

    // hits update the hit way, refills the victim
    dcache_tag_store u_tags (
        .clk         (clk),
        .reset       (reset),
        .rd_index    (rd_index),
        .tags        (tags),
        .valid       (valid),
        .dirty       (dirty),
        .lru_way     (lru_way),
        .wr_way      (in_lookup ? hit_way : lru_way),
        .tag_we      (tag_we),
        .wr_tag      (req_q.addr.fields.tag),
        .dirty_set   (in_lookup && hit && req_q.write),
        .dirty_clear (tag_we),
        .touch       (in_lookup && hit),
        .touch_way   (hit_way)
    );

    dcache_data_store u_data (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_line  (rd_line),
        .wr_way   (refill ? lru_way : hit_way),
        .wr_index (req_q.addr.fields.index),
        .wr_word  (refill ? beat_count : req_q.addr.fields.word),
        .wr_strb  (refill ? 4'hf : req_q.strb),
        .wr_data  (refill ? mem_ret_data : req_q.wdata),
        .we       (data_we_word)
    );

endmodule

`default_nettype wire

//--- tb/tb_mem_model.sv
// 1024-word memory; address bits above 11 are ignored and write bursts are taken without stalls
`default_nettype none

module tb_mem_model (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  dcache_pkg::mem_cmd_t   mem_cmd,
    input  dcache_pkg::mem_wbeat_t mem_wbeat,
    output logic                   mem_rd_rdy,
    output logic                   mem_wr_rdy,
    output logic                   mem_ret_valid,
    output dcache_pkg::word_t      mem_ret_data
);
    import dcache_pkg::*;

    word_t             words [1024];
    addr_t             last_rd_addr;
    addr_t             wb_addr_log [$];
    word_t             wb_data_log [$];
    int                rd_count = 0;
    int                wr_count = 0;
    logic              rd_rdy = 1'b0;
    logic              wr_rdy = 1'b0;
    logic              ret_valid = 1'b0;
    word_t             ret_data = '0;
    logic              returning = 1'b0;
    logic              receiving = 1'b0;
    logic [7:0]        line = '0;
    logic [WORD_W-1:0] beat = '0;

    assign mem_rd_rdy    = rd_rdy;
    assign mem_wr_rdy    = wr_rdy;
    assign mem_ret_valid = ret_valid;
    assign mem_ret_data  = ret_data;

    // outputs change on the falling edge; a stall bit holds off ready and return words
    always @(negedge clk) begin
        rd_rdy    <= 1'b0;
        wr_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        if (reset) begin
            returning <= 1'b0;
            receiving <= 1'b0;
        end else if (returning) begin
            if (!stall) begin
                ret_valid <= 1'b1;
                ret_data  <= words[{line, beat}];
                beat      <= beat + WORD_W'(1);
                returning <= (beat != WORD_W'(LINE_WORDS - 1));
            end
        end else if (receiving) begin
            // one word per cycle once the burst has started
            if (mem_wbeat.valid) begin
                words[{line, beat}] = mem_wbeat.data;
                wb_data_log.push_back(mem_wbeat.data);
                beat      <= beat + WORD_W'(1);
                receiving <= (beat != WORD_W'(LINE_WORDS - 1));
            end
        end else if (mem_cmd.wr_req && !stall) begin
            wr_rdy    <= 1'b1;
            receiving <= 1'b1;
            line      <= mem_cmd.addr.raw[11:4];
            beat      <= '0;
            wr_count  <= wr_count + 1;
            wb_addr_log.push_back(mem_cmd.addr);
        end else if (mem_cmd.rd_req && !stall) begin
            rd_rdy       <= 1'b1;
            returning    <= 1'b1;
            line         <= mem_cmd.addr.raw[11:4];
            beat         <= '0;
            rd_count     <= rd_count + 1;
            last_rd_addr <= mem_cmd.addr;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_dcache.sv
// directed tests only; every address used stays below 4 KB, the range of the memory model
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int TIMEOUT = 200;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        cpu_valid = 1'b0;
    cpu_req_t    cpu_req = '0;
    logic        cpu_done;
    word_t       cpu_rdata;
    mem_cmd_t    mem_cmd;
    mem_wbeat_t  mem_wbeat;
    logic        mem_rd_rdy;
    logic        mem_wr_rdy;
    logic        mem_ret_valid;
    word_t       mem_ret_data;
    logic        mem_stall = 1'b0;
    logic [31:0] lfsr_state = 32'hfa04;

    dcache_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .cpu_valid     (cpu_valid),
        .cpu_req       (cpu_req),
        .cpu_done      (cpu_done),
        .cpu_rdata     (cpu_rdata),
        .mem_cmd       (mem_cmd),
        .mem_wbeat     (mem_wbeat),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data)
    );

    tb_mem_model mem0 (
        .clk           (clk),
        .reset         (reset),
        .stall         (mem_stall),
        .mem_cmd       (mem_cmd),
        .mem_wbeat     (mem_wbeat),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data)
    );

    always #4 clk = ~clk;

    // one new gap bit per cycle
    always @(negedge clk) begin
        mem_stall <= (next_bits(1) == 32'd1);
    end

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic addr_t make_addr(input logic [31:0] raw);
        addr_t a;
        a.raw = raw;
        return a;
    endfunction

    function automatic word_t mem_word(input logic [31:0] addr);
        return mem0.words[addr[11:2]];
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strb_t strb);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        end
        return m;
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got.raw !== exp.raw) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
            stop_run();
        end
    endtask

    task automatic check_traffic(input string what, input int rd0, input int wr0,
                                 input int reads, input int writes);
        if (mem0.rd_count != rd0 + reads || mem0.wr_count != wr0 + writes) begin
            report_error($sformatf("%s: expected %0d line reads and %0d write-backs, saw %0d and %0d",
                what, reads, writes, mem0.rd_count - rd0, mem0.wr_count - wr0));
        end
    endtask

    task automatic check_hit_latency(input int cycles);
        if (cycles != 2) begin
            report_error($sformatf("hit took %0d cycles to cpu_done instead of 2", cycles));
        end
    endtask

    task automatic fill_memory();
        // address folded in so that no two words share a pattern
        for (int i = 0; i < 1024; i++) begin
            mem0.words[i] = next_bits(32) ^ 32'(i << 2);
        end
    endtask

    // starts and ends on a falling edge and holds the request one cycle past cpu_done
    task automatic access(input logic write, input logic [31:0] addr, input word_t wdata,
                          input strb_t strb, output word_t rdata, output int cycles);
        cpu_req.write    = write;
        cpu_req.addr.raw = addr;
        cpu_req.wdata    = wdata;
        cpu_req.strb     = strb;
        cpu_valid        = 1'b1;
        cycles           = 0;
        while (cpu_done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_error($sformatf("no cpu_done within %0d cycles at address %h",
                    TIMEOUT, addr));
            end
        end
        rdata = cpu_rdata;
        @(negedge clk);
        cpu_valid = 1'b0;
    endtask

    task automatic test_idle_after_reset();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (cpu_done !== 1'b0 || mem_cmd.rd_req !== 1'b0 || mem_cmd.wr_req !== 1'b0
                    || mem_wbeat.valid !== 1'b0) begin
                report_error("cache output active after reset with no request");
            end
        end
    endtask

    task automatic test_load_miss_then_hit();
        word_t rdata;
        word_t exp0;
        word_t exp1;
        int    cycles;
        int    rd0;
        int    wr0;
        exp0 = mem_word(32'h0124);
        exp1 = mem_word(32'h0128);
        rd0  = mem0.rd_count;
        wr0  = mem0.wr_count;
        access(1'b0, 32'h0124, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, exp0);
        check_traffic("load miss", rd0, wr0, 1, 0);
        check_addr("mem_cmd.addr", mem0.last_rd_addr, make_addr(32'h0120));
        access(1'b0, 32'h0128, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, exp1);
        check_traffic("load hit", rd0, wr0, 1, 0);
        check_hit_latency(cycles);
    endtask

    task automatic test_store_hit_merge();
        word_t rdata;
        word_t expected;
        int    cycles;
        int    rd0;
        int    wr0;
        expected = merge_bytes(mem_word(32'h0124), 32'ha5c3_1e77, 4'b0101);
        rd0      = mem0.rd_count;
        wr0      = mem0.wr_count;
        access(1'b1, 32'h0124, 32'ha5c3_1e77, 4'b0101, rdata, cycles);
        check_word("cpu_rdata", rdata, expected);
        access(1'b0, 32'h0124, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, expected);
        check_traffic("store hit", rd0, wr0, 0, 0);
        check_hit_latency(cycles);
    endtask

    task automatic test_dirty_eviction();
        word_t rdata;
        word_t line_a [LINE_WORDS];
        word_t exp_a;
        word_t exp_b;
        word_t exp_c;
        int    cycles;
        int    rd0;
        int    wr0;
        int    wb0;
        for (int k = 0; k < LINE_WORDS; k++) begin
            line_a[k] = mem_word(32'h0350 + 32'(4 * k));
        end
        exp_a = merge_bytes(line_a[1], 32'h1234_5678, 4'b1100);
        exp_b = merge_bytes(mem_word(32'h0754), 32'hcafe_f00d, 4'b0011);
        exp_c = mem_word(32'h0954);
        rd0   = mem0.rd_count;
        wr0   = mem0.wr_count;
        wb0   = mem0.wb_addr_log.size();
        access(1'b1, 32'h0354, 32'h1234_5678, 4'b1100, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_a);
        access(1'b1, 32'h0754, 32'hcafe_f00d, 4'b0011, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_b);
        check_traffic("two store misses", rd0, wr0, 2, 0);
        // set 5 is full and way 0 holds the older dirty line
        access(1'b0, 32'h0954, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_c);
        check_traffic("dirty eviction", rd0, wr0, 3, 1);
        check_addr("write-back address", mem0.wb_addr_log[wb0], make_addr(32'h0350));
        for (int k = 0; k < LINE_WORDS; k++) begin
            check_word($sformatf("write-back word %0d", k), mem0.wb_data_log[4*wb0 + k],
                (k == 1) ? exp_a : line_a[k]);
        end
        check_addr("mem_cmd.addr", mem0.last_rd_addr, make_addr(32'h0950));
    endtask

    task automatic test_replacement_order();
        word_t rdata;
        word_t exp_x;
        word_t exp_y;
        word_t exp_z;
        int    cycles;
        int    rd0;
        int    wr0;
        int    wb0;
        exp_x = mem_word(32'h0294);
        exp_y = merge_bytes(mem_word(32'h0594), 32'h0bad_beef, 4'b0110);
        exp_z = mem_word(32'h0a94);
        rd0   = mem0.rd_count;
        wr0   = mem0.wr_count;
        access(1'b0, 32'h0294, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_x);
        access(1'b1, 32'h0594, 32'h0bad_beef, 4'b0110, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_y);
        // touching x leaves y as the least recently used line
        access(1'b0, 32'h0294, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_x);
        check_traffic("fill of set 9", rd0, wr0, 2, 0);
        wb0 = mem0.wb_addr_log.size();
        access(1'b0, 32'h0a94, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_z);
        check_traffic("eviction of y", rd0, wr0, 3, 1);
        check_addr("write-back address", mem0.wb_addr_log[wb0], make_addr(32'h0590));
        check_word("write-back word 1", mem0.wb_data_log[4*wb0 + 1], exp_y);
        access(1'b0, 32'h0294, '0, '0, rdata, cycles);
        check_word("cpu_rdata", rdata, exp_x);
        check_traffic("reload of x", rd0, wr0, 3, 1);
        check_hit_latency(cycles);
    endtask

    initial begin
        fill_memory();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        test_idle_after_reset();
        test_load_miss_then_hit();
        test_store_hit_merge();
        test_dirty_eviction();
        test_replacement_order();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache.f
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_beat_counter.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

//--- Makefile
# Verilator build and run of the dcache testbench

SRCS := $(shell cat dcache.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_dcache: dcache.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f dcache.f

run: obj_dir/Vtb_dcache
	./obj_dir/Vtb_dcache | tee sim.log
	@if grep -q "Some tests failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
